//--- requant_stimulus.txt
# columns: test_id accumulator(hex Q10.6) result(hex Q6.2) sat hold_cycles
# hold_cycles delays the sink credit of that result
zero          0000 00 0 0
exact_pos     0010 01 0 0
exact_neg     fff0 ff 0 0
below_half_p  0017 01 0 1
above_half_p  0019 02 0 0
below_half_n  ffe9 ff 0 0
above_half_n  ffe7 fe 0 40
small_pos     0007 00 0 0
small_neg     fff9 00 0 0
tie_pos       0008 01 0 0
tie_neg       fff8 ff 0 0
tie_pos_2     0018 02 0 0
tie_neg_2     ffe8 fe 0 2
max_exact     07f0 7f 0 0
max_round_dn  07f7 7f 0 0
max_tie_up    07e8 7f 0 0
sat_pos_tie   07f8 7f 1 0
sat_pos_edge  0800 7f 1 0
sat_pos_big   7fff 7f 1 3
min_exact     f800 80 0 0
min_tie       f808 80 0 0
sat_neg_tie   f7f8 80 1 0
sat_neg_edge  f7f0 80 1 30
sat_neg_big   8000 80 1 0
mid_pos       0123 12 0 0
mid_neg       fedc ee 0 0
half_pos      0158 16 0 0
half_neg      fea8 ea 0 0
near_pos      00ff 10 0 1
near_neg      ff01 f0 0 0
big_pos       0400 40 0 0
big_neg       fc00 c0 0 0
sat_pos_mid   0a5a 7f 1 0

//--- tb.f
requant_pkg.sv
requant_lane_if.sv
fixed_round.sv
requant_lane.sv
requant_dispatch.sv
requant_collect.sv
requant_array.sv
tb_requant_array.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_requant_array
FILELIST  := tb.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
VFLAGS    += --top-module $(TOP) -Mdir $(OBJ_DIR)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build output"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_requant_array.sv
`timescale 1ns/1ps
`default_nettype none

module tb_requant_array;

  localparam int    RESET_CYCLES = 8;
  localparam int    TIMEOUT      = 2000;
  // credits the source and the sink hold after reset
  localparam int    SRC_CREDITS  = 4;
  localparam int    SNK_CREDITS  = 4;
  localparam int    IDLE_CYCLES  = 4;
  localparam string STIM_FILE    = "requant_stimulus.txt";

  logic              clk;
  logic              arst_n;
  logic              in_valid;
  requant_pkg::acc_t in_acc;
  logic              in_credit;
  logic              out_valid;
  requant_pkg::res_t out_res;
  logic              out_sat;
  logic              out_credit;

  // vector table, one entry per stimulus line
  string             name_q [$];
  requant_pkg::acc_t acc_q [$];
  requant_pkg::res_t res_q [$];
  logic              sat_q [$];
  int                hold_q [$];

  // hold cycles of results still waiting for their sink credit
  int                pending_q [$];

  int                src_credits;
  int                n_sent;
  int                n_in_credit;
  int                n_checked;
  int                n_out_credit;
  int                seed;

  requant_array u_dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .in_acc     (in_acc),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_res    (out_res),
    .out_sat    (out_sat),
    .out_credit (out_credit)
  );

  always #5 clk = ~clk;

  task automatic stop_with_failure();
    $display("test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_res(input string name, input requant_pkg::res_t exp,
                           input requant_pkg::res_t act);
    if (act !== exp) begin
      $display("ERROR %s: result expected %0d, actual %0d", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_sat(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %s: sat expected %0b, actual %0b", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic load_vectors();
    int                fd;
    int                n;
    string             line;
    string             name;
    requant_pkg::acc_t acc;
    requant_pkg::res_t res;
    int                sat;
    int                hold;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file %s", STIM_FILE);
      stop_with_failure();
    end
    while ($fgets(line, fd) != 0) begin
      // comment and blank lines carry no vector
      if (line.len() < 3 || line[0] == "#") begin
        continue;
      end
      n = $sscanf(line, "%s %h %h %d %d", name, acc, res, sat, hold);
      if (n != 5) begin
        $display("malformed stimulus line: %s", line);
        stop_with_failure();
      end
      name_q.push_back(name);
      acc_q.push_back(acc);
      res_q.push_back(res);
      sat_q.push_back(sat != 0);
      hold_q.push_back(hold);
    end
    $fclose(fd);
    if (name_q.size() == 0) begin
      $display("the stimulus file holds no vectors");
      stop_with_failure();
    end
  endtask

  // source, sends back to back while it holds credits
  task automatic send_vectors();
    int idle;
    @(posedge clk);
    #1;
    for (int i = 0; i < name_q.size(); i++) begin
      idle = 0;
      while (src_credits == 0) begin
        @(posedge clk);
        #1;
        idle++;
        if (idle > TIMEOUT) begin
          $display("timeout waiting for an input credit from the DUT");
          stop_with_failure();
        end
      end
      in_valid = 1'b1;
      in_acc   = acc_q[i];
      src_credits--;
      n_sent++;
      @(posedge clk);
      #1;
      in_valid = 1'b0;
    end
  endtask

  // sink credit return, in result order
  task automatic return_credits();
    int          idle;
    int          gap;
    logic [31:0] rnd;
    @(posedge clk);
    #1;
    for (int i = 0; i < name_q.size(); i++) begin
      idle = 0;
      while (pending_q.size() == 0) begin
        @(posedge clk);
        #1;
        idle++;
        if (idle > TIMEOUT) begin
          $display("timeout waiting for a result to hand back its credit");
          stop_with_failure();
        end
      end
      gap = pending_q.pop_front();
      // now and then an extra random delay on top of the vector's hold
      rnd = $random(seed);
      if (rnd[1:0] == 2'b00) begin
        gap = gap + int'(rnd[6:4]);
      end
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
      out_credit = 1'b1;
      n_out_credit++;
      @(posedge clk);
      #1;
      out_credit = 1'b0;
    end
  endtask

  // outputs are registered, so the falling edge sees them stable
  always @(negedge clk) begin
    if (arst_n) begin
      if (in_credit) begin
        n_in_credit++;
        src_credits++;
        if (n_in_credit > n_sent) begin
          $display("the DUT returned more input credits than items sent");
          stop_with_failure();
        end
      end
      if (out_valid) begin
        if (n_checked >= name_q.size()) begin
          $display("the DUT produced more results than vectors sent");
          stop_with_failure();
        end
        if (n_checked + 1 > SNK_CREDITS + n_out_credit) begin
          $display("out_valid without a sink credit at result %0d", n_checked);
          stop_with_failure();
        end
        check_res(name_q[n_checked], res_q[n_checked], out_res);
        check_sat(name_q[n_checked], sat_q[n_checked], out_sat);
        pending_q.push_back(hold_q[n_checked]);
        n_checked++;
      end
    end
  end

  initial begin : main
    int idle;
    int last;
    clk          = 1'b0;
    arst_n       = 1'b0;
    in_valid     = 1'b0;
    in_acc       = '0;
    out_credit   = 1'b0;
    seed         = 32'hf37e_8061;
    src_credits  = SRC_CREDITS;
    n_sent       = 0;
    n_in_credit  = 0;
    n_checked    = 0;
    n_out_credit = 0;
    load_vectors();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    arst_n = 1'b1;
    // quiet after reset until the first input
    repeat (IDLE_CYCLES) begin
      @(negedge clk);
      if (out_valid || in_credit) begin
        $display("output or input credit activity before any input was sent");
        stop_with_failure();
      end
    end
    fork
      send_vectors();
      return_credits();
    join_none
    // watchdog restarts on every checked result
    idle = 0;
    last = 0;
    while (n_checked < name_q.size() && idle < TIMEOUT) begin
      @(posedge clk);
      idle = (n_checked == last) ? idle + 1 : 0;
      last = n_checked;
    end
    // every issued item hands its input credit back well before its result
    if (n_checked != name_q.size()) begin
      $display("timeout waiting for results, %0d of %0d checked", n_checked, name_q.size());
      stop_with_failure();
    end else if (n_in_credit != n_sent) begin
      $display("the DUT returned %0d input credits for %0d items sent", n_in_credit, n_sent);
      stop_with_failure();
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- requant_array.sv
`timescale 1ns/1ps
`default_nettype none

module requant_array #(
  parameter int NUM_LANES   = 4,
  parameter int LANE_DEPTH  = 2,
  parameter int IN_DEPTH    = 4,
  parameter int OUT_CREDITS = 4
) (
  input  logic               clk,
  input  logic               arst_n,
  // source side, credit based
  input  logic               in_valid,
  input  requant_pkg::acc_t  in_acc,
  output logic               in_credit,
  // sink side, credit based
  output logic               out_valid,
  output requant_pkg::res_t  out_res,
  output logic               out_sat,
  input  logic               out_credit
);

  // one link per lane, shared by dispatcher, lane and collector
  requant_lane_if lane_if [NUM_LANES] (.clk(clk));

  requant_dispatch #(
    .NUM_LANES  (NUM_LANES),
    .LANE_DEPTH (LANE_DEPTH),
    .IN_DEPTH   (IN_DEPTH)
  ) u_dispatch (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_acc    (in_acc),
    .in_credit (in_credit),
    .lanes     (lane_if)
  );

  // identical rounding lanes, fed and drained round robin
  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    requant_lane #(
      .LANE_DEPTH (LANE_DEPTH)
    ) u_lane (
      .clk     (clk),
      .arst_n  (arst_n),
      .lane_if (lane_if[g])
    );
  end

  requant_collect #(
    .NUM_LANES   (NUM_LANES),
    .OUT_CREDITS (OUT_CREDITS)
  ) u_collect (
    .clk        (clk),
    .arst_n     (arst_n),
    .lanes      (lane_if),
    .out_valid  (out_valid),
    .out_res    (out_res),
    .out_sat    (out_sat),
    .out_credit (out_credit)
  );

endmodule

`default_nettype wire

//--- requant_collect.sv
`timescale 1ns/1ps
`default_nettype none

module requant_collect #(
  parameter int NUM_LANES   = 4,
  parameter int OUT_CREDITS = 4
) (
  input  logic               clk,
  input  logic               arst_n,
  requant_lane_if.collect    lanes [NUM_LANES],
  output logic               out_valid,
  output requant_pkg::res_t  out_res,
  output logic               out_sat,
  input  logic               out_credit
);

  localparam int LW = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

  logic [LW-1:0]        rr_ptr;
  requant_pkg::cnt_t    out_cnt;
  logic                 pop;
  logic [NUM_LANES-1:0] vld_vec;
  requant_pkg::res_t    res_arr [NUM_LANES];
  logic [NUM_LANES-1:0] sat_vec;

  // gather lane heads and fan out the pop strobe
  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    assign vld_vec[g]   = lanes[g].res_valid;
    assign res_arr[g]   = lanes[g].res;
    assign sat_vec[g]   = lanes[g].sat;
    assign lanes[g].pop = pop && (rr_ptr == LW'(g));
  end

  // drain only the lane in turn, which keeps input order
  // and only while the sink has room
  assign pop = vld_vec[rr_ptr] && (out_cnt != '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rr_ptr    <= '0;
      out_cnt   <= requant_pkg::cnt_t'(OUT_CREDITS);
      out_valid <= 1'b0;
    end else begin
      if (pop) begin
        rr_ptr <= (rr_ptr == LW'(NUM_LANES - 1)) ? '0 : rr_ptr + 1'b1;
      end
      // credit spent at pop, returned by the sink later
      out_cnt   <= out_cnt - requant_pkg::cnt_t'(pop) + requant_pkg::cnt_t'(out_credit);
      out_valid <= pop;
    end
  end

  // output payload, qualified by out_valid
  always_ff @(posedge clk) begin
    if (pop) begin
      out_res <= res_arr[rr_ptr];
      out_sat <= sat_vec[rr_ptr];
    end
  end

  // the sink never hands back more than it was given
  a_out_cnt_max: assert property (@(posedge clk) disable iff (!arst_n)
    out_cnt <= requant_pkg::cnt_t'(OUT_CREDITS))
    else $error("output credit counter above limit");

endmodule

`default_nettype wire

//--- requant_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module requant_dispatch #(
  parameter int NUM_LANES  = 4,
  parameter int LANE_DEPTH = 2,
  parameter int IN_DEPTH   = 4
) (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    in_valid,
  input  requant_pkg::acc_t       in_acc,
  output logic                    in_credit,
  requant_lane_if.dispatch        lanes [NUM_LANES]
);

  localparam int IW = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
  localparam int LW = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

  // input buffer
  requant_pkg::acc_t buf_mem [IN_DEPTH];
  logic [IW-1:0]     wr_ptr;
  logic [IW-1:0]     rd_ptr;
  requant_pkg::cnt_t count;

  // issue side
  logic [LW-1:0]     rr_ptr;
  requant_pkg::cnt_t lane_cnt [NUM_LANES];
  logic              head_vld;
  requant_pkg::acc_t head_acc;
  logic              issue;
  logic              buf_wr;
  logic              buf_rd;
  logic [NUM_LANES-1:0] push_vec;
  logic [NUM_LANES-1:0] credit_vec;

  // an empty buffer lets the incoming item go out in the same cycle
  assign head_vld = (count != '0) || in_valid;
  assign head_acc = (count != '0) ? buf_mem[rd_ptr] : in_acc;
  assign issue    = head_vld && (lane_cnt[rr_ptr] != '0);

  // bypassed items never touch the buffer
  assign buf_wr = in_valid && !(issue && (count == '0));
  assign buf_rd = issue && (count != '0);

  always_ff @(posedge clk) begin
    if (buf_wr) begin
      buf_mem[wr_ptr] <= in_acc;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      rr_ptr    <= '0;
      in_credit <= 1'b0;
      for (int i = 0; i < NUM_LANES; i++) begin
        lane_cnt[i] <= requant_pkg::cnt_t'(LANE_DEPTH);
      end
    end else begin
      if (buf_wr) begin
        wr_ptr <= (wr_ptr == IW'(IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (buf_rd) begin
        rd_ptr <= (rd_ptr == IW'(IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + requant_pkg::cnt_t'(buf_wr) - requant_pkg::cnt_t'(buf_rd);
      // next lane in turn after every issue
      if (issue) begin
        rr_ptr <= (rr_ptr == LW'(NUM_LANES - 1)) ? '0 : rr_ptr + 1'b1;
      end
      // one source credit back per issued item, a cycle later
      in_credit <= issue;
      // spend on push, refill on lane credit
      for (int i = 0; i < NUM_LANES; i++) begin
        lane_cnt[i] <= lane_cnt[i] - requant_pkg::cnt_t'(push_vec[i])
                                   + requant_pkg::cnt_t'(credit_vec[i]);
      end
    end
  end

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    assign push_vec[g]    = issue && (rr_ptr == LW'(g));
    assign lanes[g].push  = push_vec[g];
    assign lanes[g].acc   = head_acc;
    assign credit_vec[g]  = lanes[g].credit;

    a_lane_cnt_max: assert property (@(posedge clk) disable iff (!arst_n)
      lane_cnt[g] <= requant_pkg::cnt_t'(LANE_DEPTH))
      else $error("lane credit counter above lane depth");
  end

  // the source only sends while it holds a credit
  a_no_in_full: assert property (@(posedge clk) disable iff (!arst_n)
    in_valid |-> (count < requant_pkg::cnt_t'(IN_DEPTH)))
    else $error("input while the buffer is full");

endmodule

`default_nettype wire

//--- requant_lane.sv
`timescale 1ns/1ps
`default_nettype none

module requant_lane #(
  parameter int LANE_DEPTH = 2
) (
  input  logic           clk,
  input  logic           arst_n,
  requant_lane_if.lane   lane_if
);

  localparam int PW = (LANE_DEPTH > 1) ? $clog2(LANE_DEPTH) : 1;

  // input stage
  logic              acc_vld;
  requant_pkg::acc_t acc_q;

  // rounder output
  requant_pkg::res_t rnd_res;
  logic              rnd_sat;

  // output queue
  requant_pkg::res_t mem_res [LANE_DEPTH];
  logic              mem_sat [LANE_DEPTH];
  logic [PW-1:0]     wr_ptr;
  logic [PW-1:0]     rd_ptr;
  requant_pkg::cnt_t count;
  requant_pkg::cnt_t occupancy;

  // register the issued accumulator, only the valid bit is reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      acc_vld <= 1'b0;
    end else begin
      acc_vld <= lane_if.push;
    end
  end

  always_ff @(posedge clk) begin
    if (lane_if.push) begin
      acc_q <= lane_if.acc;
    end
  end

  fixed_round u_round (
    .acc (acc_q),
    .res (rnd_res),
    .sat (rnd_sat)
  );

  // queue storage, written the cycle after issue
  always_ff @(posedge clk) begin
    if (acc_vld) begin
      mem_res[wr_ptr] <= rnd_res;
      mem_sat[wr_ptr] <= rnd_sat;
    end
  end

  // pointers, fill level, and the credit echo of each pop
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr         <= '0;
      rd_ptr         <= '0;
      count          <= '0;
      lane_if.credit <= 1'b0;
    end else begin
      if (acc_vld) begin
        wr_ptr <= (wr_ptr == PW'(LANE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (lane_if.pop) begin
        rd_ptr <= (rd_ptr == PW'(LANE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count          <= count + requant_pkg::cnt_t'(acc_vld)
                              - requant_pkg::cnt_t'(lane_if.pop);
      lane_if.credit <= lane_if.pop;
    end
  end

  // head of the queue goes straight to the collector
  assign lane_if.res_valid = (count != '0);
  assign lane_if.res       = mem_res[rd_ptr];
  assign lane_if.sat       = mem_sat[rd_ptr];

  // items held in the lane, register plus queue
  assign occupancy = count + requant_pkg::cnt_t'(acc_vld);

  // dispatcher credits must keep the lane from overfilling
  a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
    lane_if.push |-> (occupancy < requant_pkg::cnt_t'(LANE_DEPTH)))
    else $error("push into a full lane");

  a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
    lane_if.pop |-> (count != '0))
    else $error("pop from an empty lane");

endmodule

`default_nettype wire

//--- fixed_round.sv
`timescale 1ns/1ps
`default_nettype none

module fixed_round (
  input  requant_pkg::acc_t acc,
  output requant_pkg::res_t res,
  output logic              sat
);

  localparam int AW    = requant_pkg::ACC_W;
  localparam int RW    = requant_pkg::RES_W;
  localparam int SHIFT = requant_pkg::SHIFT;
  // width of the rounded magnitude
  localparam int QW    = AW - SHIFT;

  // half of one output lsb, in input lsbs
  localparam logic [AW-1:0] HALF = AW'(1 << (SHIFT - 1));

  // largest magnitudes that still fit, per sign
  localparam logic [QW-1:0] POS_LIM = QW'(requant_pkg::RES_MAX);
  localparam logic [QW-1:0] NEG_LIM = QW'(-int'(requant_pkg::RES_MIN));

  logic          neg;
  logic [AW-1:0] mag;
  logic [AW-1:0] mag_rnd;
  logic [QW-1:0] q;
  logic [RW-1:0] q_low;
  logic [RW-1:0] q_neg;

  // sign and magnitude, -32768 maps to 32768 which still fits unsigned
  assign neg = acc[AW-1];
  assign mag = neg ? (~acc + 1'b1) : acc;

  // add half an output lsb then drop the low bits
  // every dropped bit takes part through the carry
  // rounding the magnitude gives ties away from zero
  assign mag_rnd = mag + HALF;
  assign q       = mag_rnd[AW-1:SHIFT];

  // low part of the magnitude and its two's complement
  assign q_low = q[RW-1:0];
  assign q_neg = ~q_low + 1'b1;

  always_comb begin
    sat = 1'b0;
    res = requant_pkg::res_t'(q_low);
    if (neg) begin
      // 128 still fits on the negative side
      if (q > NEG_LIM) begin
        sat = 1'b1;
        res = requant_pkg::RES_MIN;
      end else begin
        res = requant_pkg::res_t'(q_neg);
      end
    end else if (q > POS_LIM) begin
      sat = 1'b1;
      res = requant_pkg::RES_MAX;
    end
  end

endmodule

`default_nettype wire

//--- requant_lane_if.sv
`timescale 1ns/1ps
`default_nettype none

interface requant_lane_if (
  input logic clk
);

  // issue side, dispatcher to lane
  logic               push;
  requant_pkg::acc_t  acc;

  // credit back to the dispatcher, one pulse per entry leaving the queue
  logic               credit;

  // head of the lane queue
  logic               res_valid;
  requant_pkg::res_t  res;
  logic               sat;

  // drain strobe from the collector
  logic               pop;

  modport dispatch (
    output push,
    output acc,
    input  credit
  );

  modport lane (
    input  push,
    input  acc,
    output credit,
    output res_valid,
    output res,
    output sat,
    input  pop
  );

  modport collect (
    input  res_valid,
    input  res,
    input  sat,
    output pop
  );

endinterface

`default_nettype wire

//--- requant_pkg.sv
`default_nettype none

package requant_pkg;

  // accumulator format, Q10.6
  localparam int ACC_W    = 16;
  localparam int ACC_FRAC = 6;

  // result format, Q6.2
  localparam int RES_W    = 8;
  localparam int RES_FRAC = 2;

  // low bits removed by rounding
  localparam int SHIFT = ACC_FRAC - RES_FRAC;

  // credit counter width, covers depths up to 15
  localparam int CNT_W = 4;

  // signed accumulator sample from the MAC array
  typedef logic signed [ACC_W-1:0] acc_t;

  // signed requantized result code
  typedef logic signed [RES_W-1:0] res_t;

  // credit / occupancy counter
  typedef logic [CNT_W-1:0] cnt_t;

  // clamp limits in raw output codes
  localparam res_t RES_MAX = res_t'(127);
  localparam res_t RES_MIN = res_t'(-128);

endpackage

`default_nettype wire
